// File: src/rs_pkg.sv
package rs_pkg;

    localparam int RS_SIZE = 16;  // fixed by the shape of the selector trees.
    localparam int TAG_W   = 6;
    localparam int DATA_W  = 32;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5
    } alu_op_t;

    typedef struct packed {
        logic              ready;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] value;
    } src_t;

    // widths of an entry and of a result, not counting the pc in front.
    localparam int ENTRY_BASE_W  = $bits(alu_op_t) + TAG_W + 2 * $bits(src_t);
    localparam int RESULT_BASE_W = TAG_W + DATA_W;

    // a waiting source picks up a broadcast whose tag matches its own.
    function automatic src_t snoop_src(input src_t              s,
                                       input logic              hit_valid,
                                       input logic [TAG_W-1:0]  hit_tag,
                                       input logic [DATA_W-1:0] hit_value);
        src_t r;
        r = s;
        if (hit_valid && !s.ready && s.tag == hit_tag) begin
            r.ready = 1'b1;
            r.value = hit_value;
        end
        return r;
    endfunction

endpackage

// File: src/ps_tree.sv
// ============================
// fixed-priority grant trees, highest index wins.
// ============================

module ps2 (
    input  logic [1:0] req,
    input  logic       en,
    output logic [1:0] gnt,
    output logic       req_up
);
    always_comb begin
        gnt = 2'b00;
        if (en) begin
            if (req[1]) begin
                gnt = 2'b10;
            end else if (req[0]) begin
                gnt = 2'b01;
            end
        end
    end

    assign req_up = |req;
endmodule

module ps4 (
    input  logic [3:0] req,
    input  logic       en,
    output logic [3:0] gnt,
    output logic       req_up
);
    logic [1:0] half_req;  // a request is pending in that half.
    logic [1:0] half_en;

    for (genvar h = 0; h < 2; h++) begin : g_half
        ps2 u_leaf (
            .req    (req[2*h+1 -: 2]),
            .en     (half_en[h]),
            .gnt    (gnt[2*h+1 -: 2]),
            .req_up (half_req[h])
        );
    end

    ps2 u_root (.req(half_req), .en(en), .gnt(half_en), .req_up(req_up));
endmodule

module ps16 (
    input  logic [15:0] req,
    input  logic        en,
    output logic [15:0] gnt,
    output logic        req_up
);
    logic [3:0] quad_req;
    logic [3:0] quad_en;

    for (genvar q = 0; q < 4; q++) begin : g_quad
        ps4 u_leaf (
            .req    (req[4*q+3 -: 4]),
            .en     (quad_en[q]),
            .gnt    (gnt[4*q+3 -: 4]),
            .req_up (quad_req[q])
        );
    end

    ps4 u_root (.req(quad_req), .en(en), .gnt(quad_en), .req_up(req_up));
endmodule

// File: src/pc_sel.sv
// ============================
// oldest-pc grant trees.
// ============================

module pc_sel2 #(
    parameter int PC_W = 32
) (
    input  logic [1:0][PC_W-1:0] pc,
    input  logic [1:0]           req,
    input  logic                 en,
    output logic [1:0]           gnt,
    output logic                 req_up,
    output logic [PC_W-1:0]      pc_up
);
    logic [1:0] pick;
    logic       hi_older;  // strict compare, so equal pcs go to index 0.

    assign hi_older = pc[1] < pc[0];
    assign req_up   = |req;
    assign gnt      = en ? pick : 2'b00;

    always_comb begin
        case (req)
            2'b11: begin
                pick  = hi_older ? 2'b10 : 2'b01;
                pc_up = hi_older ? pc[1] : pc[0];
            end
            2'b10: begin
                pick  = 2'b10;
                pc_up = pc[1];
            end
            2'b01: begin
                pick  = 2'b01;
                pc_up = pc[0];
            end
            default: begin
                pick  = 2'b00;
                pc_up = '1;  // loses every compare above.
            end
        endcase
    end
endmodule

module pc_sel4 #(
    parameter int PC_W = 32
) (
    input  logic [3:0][PC_W-1:0] pc,
    input  logic [3:0]           req,
    input  logic                 en,
    output logic [3:0]           gnt,
    output logic                 req_up,
    output logic [PC_W-1:0]      pc_up
);
    logic [1:0]           child_req;
    logic [1:0][PC_W-1:0] child_pc;
    logic [1:0]           child_en;

    for (genvar h = 0; h < 2; h++) begin : g_half
        pc_sel2 #(.PC_W(PC_W)) u_leaf (
            .pc     (pc[2*h+1 -: 2]),
            .req    (req[2*h+1 -: 2]),
            .en     (child_en[h]),
            .gnt    (gnt[2*h+1 -: 2]),
            .req_up (child_req[h]),
            .pc_up  (child_pc[h])
        );
    end

    // the root grant enables only the winning half.
    pc_sel2 #(.PC_W(PC_W)) u_root (
        .pc(child_pc), .req(child_req), .en(en),
        .gnt(child_en), .req_up(req_up), .pc_up(pc_up)
    );
endmodule

module pc_sel16 #(
    parameter int PC_W = 32
) (
    input  logic [15:0][PC_W-1:0] pc,
    input  logic [15:0]           req,
    input  logic                  en,
    output logic [15:0]           gnt,
    output logic                  req_up,
    output logic [PC_W-1:0]       pc_up
);
    logic [3:0]           child_req;
    logic [3:0][PC_W-1:0] child_pc;
    logic [3:0]           child_en;

    for (genvar q = 0; q < 4; q++) begin : g_quad
        pc_sel4 #(.PC_W(PC_W)) u_leaf (
            .pc     (pc[4*q+3 -: 4]),
            .req    (req[4*q+3 -: 4]),
            .en     (child_en[q]),
            .gnt    (gnt[4*q+3 -: 4]),
            .req_up (child_req[q]),
            .pc_up  (child_pc[q])
        );
    end

    pc_sel4 #(.PC_W(PC_W)) u_root (
        .pc(child_pc), .req(child_req), .en(en),
        .gnt(child_en), .req_up(req_up), .pc_up(pc_up)
    );
endmodule

// File: src/rs_dispatch.sv
module rs_dispatch import rs_pkg::*; #(
    parameter int PC_W = 32
) (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            dispatch_en,
    input  logic [PC_W+ENTRY_BASE_W-1:0]    dispatch_entry,
    input  logic [RS_SIZE-1:0]              free,
    input  logic                            broadcast_valid,
    input  logic [PC_W+RESULT_BASE_W-1:0]   broadcast,
    output logic                            write_en,
    output logic [RS_SIZE-1:0]              write_slot,
    output logic [PC_W+ENTRY_BASE_W-1:0]    write_entry,
    output logic                            full
);
    typedef struct packed {
        logic [PC_W-1:0]  pc;
        alu_op_t          op;
        logic [TAG_W-1:0] dest_tag;
        src_t             src1;
        src_t             src2;
    } rs_entry_t;

    typedef struct packed {
        logic [PC_W-1:0]   pc;
        logic [TAG_W-1:0]  dest_tag;
        logic [DATA_W-1:0] value;
    } result_t;

    rs_entry_t in_s;
    rs_entry_t out_s;
    result_t   bc_s;
    logic      any_free;

    assign in_s = dispatch_entry;
    assign bc_s = broadcast;

    // the tree only grants while a dispatch is being offered.
    ps16 u_free_sel (.req(free), .en(dispatch_en), .gnt(write_slot), .req_up(any_free));

    assign full     = ~any_free;
    assign write_en = dispatch_en & any_free;  // strobes while full are dropped.

    always_comb begin
        out_s      = in_s;
        out_s.src1 = snoop_src(in_s.src1, broadcast_valid, bc_s.dest_tag, bc_s.value);
        out_s.src2 = snoop_src(in_s.src2, broadcast_valid, bc_s.dest_tag, bc_s.value);
    end

    assign write_entry = out_s;
endmodule

// File: src/rs_table.sv
module rs_table import rs_pkg::*; #(
    parameter int PC_W = 32
) (
    input  logic                                      clock,
    input  logic                                      rst,
    input  logic                                      write_en,
    input  logic [RS_SIZE-1:0]                        write_slot,
    input  logic [PC_W+ENTRY_BASE_W-1:0]              write_entry,
    input  logic [RS_SIZE-1:0]                        issue_gnt,
    input  logic                                      broadcast_valid,
    input  logic [PC_W+RESULT_BASE_W-1:0]             broadcast,
    output logic [RS_SIZE-1:0]                        free,
    output logic [RS_SIZE-1:0]                        ready,
    output logic [RS_SIZE-1:0][PC_W+ENTRY_BASE_W-1:0] entries
);
    typedef struct packed {
        logic [PC_W-1:0]  pc;
        alu_op_t          op;
        logic [TAG_W-1:0] dest_tag;
        src_t             src1;
        src_t             src2;
    } rs_entry_t;

    typedef struct packed {
        logic [PC_W-1:0]   pc;
        logic [TAG_W-1:0]  dest_tag;
        logic [DATA_W-1:0] value;
    } result_t;

    // ============================
    // state
    // ============================

    logic      [RS_SIZE-1:0] occupied;
    rs_entry_t [RS_SIZE-1:0] entry_q;
    rs_entry_t               wr_s;
    result_t                 bc_s;
    logic      [RS_SIZE-1:0] set_mask;

    assign wr_s     = write_entry;
    assign bc_s     = broadcast;
    assign set_mask = write_en ? write_slot : '0;

    // the issued slot is always occupied and the written one always free,
    // so clearing first and setting second never collide.
    always_ff @(posedge clock) begin
        if (rst) begin
            occupied <= '0;
        end else begin
            occupied <= (occupied & ~issue_gnt) | set_mask;
        end
    end

    // ============================
    // payload and wakeup
    // ============================

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (set_mask[i]) begin
                entry_q[i] <= wr_s;  // already merged with this cycle's broadcast.
            end else begin
                entry_q[i].src1 <= snoop_src(entry_q[i].src1, broadcast_valid,
                                             bc_s.dest_tag, bc_s.value);
                entry_q[i].src2 <= snoop_src(entry_q[i].src2, broadcast_valid,
                                             bc_s.dest_tag, bc_s.value);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            ready[i] = occupied[i] & entry_q[i].src1.ready & entry_q[i].src2.ready;
        end
    end

    assign free    = ~occupied;
    assign entries = entry_q;
endmodule

// File: src/rs_issue.sv
module rs_issue import rs_pkg::*; #(
    parameter int PC_W = 32
) (
    input  logic                                      clock,
    input  logic                                      rst,
    input  logic [RS_SIZE-1:0]                        ready,
    input  logic [RS_SIZE-1:0][PC_W+ENTRY_BASE_W-1:0] entries,
    output logic [RS_SIZE-1:0]                        issue_gnt,
    output logic                                      result_valid,
    output logic [PC_W+RESULT_BASE_W-1:0]             result
);
    typedef struct packed {
        logic [PC_W-1:0]  pc;
        alu_op_t          op;
        logic [TAG_W-1:0] dest_tag;
        src_t             src1;
        src_t             src2;
    } rs_entry_t;

    typedef struct packed {
        logic [PC_W-1:0]   pc;
        logic [TAG_W-1:0]  dest_tag;
        logic [DATA_W-1:0] value;
    } result_t;

    rs_entry_t [RS_SIZE-1:0]           entry_s;
    logic      [RS_SIZE-1:0][PC_W-1:0] pcs;
    logic                              any_ready;
    logic      [PC_W-1:0]              oldest_pc;
    rs_entry_t                         sel;
    logic      [DATA_W-1:0]            a;
    logic      [DATA_W-1:0]            b;
    logic      [DATA_W-1:0]            alu_out;
    result_t                           result_q;

    assign entry_s = entries;

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            pcs[i] = entry_s[i].pc;
        end
    end

    pc_sel16 #(.PC_W(PC_W)) u_oldest (
        .pc(pcs), .req(ready), .en(1'b1),
        .gnt(issue_gnt), .req_up(any_ready), .pc_up(oldest_pc)
    );

    // one-hot mux, an OR of the masked entries.
    always_comb begin
        sel = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            sel = sel | (entry_s[i] & {$bits(rs_entry_t){issue_gnt[i]}});
        end
    end

    assign a = sel.src1.value;
    assign b = sel.src2.value;

    always_comb begin
        case (sel.op)
            ADD:     alu_out = a + b;
            SUB:     alu_out = a - b;
            AND:     alu_out = a & b;
            OR:      alu_out = a | b;
            XOR:     alu_out = a ^ b;
            SLT:     alu_out = {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= any_ready;
        end
    end

    always_ff @(posedge clock) begin
        if (any_ready) begin
            result_q <= '{pc: oldest_pc, dest_tag: sel.dest_tag, value: alu_out};
        end
    end

    assign result = result_q;
endmodule

// File: src/rs_top.sv
module rs_top import rs_pkg::*; #(
    parameter int PC_W = 32
) (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          dispatch_en,
    input  logic [PC_W+ENTRY_BASE_W-1:0]  dispatch_entry,
    output logic                          full,
    output logic                          result_valid,
    output logic [PC_W+RESULT_BASE_W-1:0] result
);
    logic                                      write_en;
    logic [RS_SIZE-1:0]                        write_slot;
    logic [PC_W+ENTRY_BASE_W-1:0]              write_entry;
    logic [RS_SIZE-1:0]                        free;
    logic [RS_SIZE-1:0]                        ready;
    logic [RS_SIZE-1:0][PC_W+ENTRY_BASE_W-1:0] entries;
    logic [RS_SIZE-1:0]                        issue_gnt;

    rs_dispatch #(.PC_W(PC_W)) u_dispatch (
        .clock(clock), .rst(rst),
        .dispatch_en(dispatch_en), .dispatch_entry(dispatch_entry), .free(free),
        .broadcast_valid(result_valid), .broadcast(result),
        .write_en(write_en), .write_slot(write_slot), .write_entry(write_entry),
        .full(full)
    );

    rs_table #(.PC_W(PC_W)) u_table (
        .clock(clock), .rst(rst),
        .write_en(write_en), .write_slot(write_slot), .write_entry(write_entry),
        .issue_gnt(issue_gnt),
        .broadcast_valid(result_valid), .broadcast(result),
        .free(free), .ready(ready), .entries(entries)
    );

    // the registered result is also the wakeup broadcast.
    rs_issue #(.PC_W(PC_W)) u_issue (
        .clock(clock), .rst(rst),
        .ready(ready), .entries(entries),
        .issue_gnt(issue_gnt),
        .result_valid(result_valid), .result(result)
    );
endmodule

// File: tb/rs_clock_gen.sv
module rs_clock_gen (
    output logic clock,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);  // five rising edges see reset high.
        rst = 1'b0;
    end
endmodule

// File: tb/rs_checker.sv
module rs_checker import rs_pkg::*; #(
    parameter int PC_W = 32
) (
    input logic                          clock,
    input logic                          rst,
    input logic                          dispatch_en,
    input logic [PC_W+ENTRY_BASE_W-1:0]  dispatch_entry,
    input logic                          full,
    input logic                          result_valid,
    input logic [PC_W+RESULT_BASE_W-1:0] result
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [PC_W-1:0]  pc;
        alu_op_t          op;
        logic [TAG_W-1:0] dest_tag;
        src_t             src1;
        src_t             src2;
    } rs_entry_t;

    typedef struct packed {
        logic [PC_W-1:0]   pc;
        logic [TAG_W-1:0]  dest_tag;
        logic [DATA_W-1:0] value;
    } result_t;

    localparam int NTAGS = 1 << TAG_W;

    rs_entry_t         in_s;
    result_t           res_s;
    logic              accept;
    int                error_count = 0;
    int                occ;  // entries accepted minus results seen.
    logic              seen_dispatch;
    logic [NTAGS-1:0]  pending;
    logic [NTAGS-1:0]  produced;
    alu_op_t           op_q [NTAGS];
    src_t              s1_q [NTAGS];
    src_t              s2_q [NTAGS];
    logic [DATA_W-1:0] prod_val [NTAGS];
    logic              prev_valid;
    logic              prev2_valid;
    logic              acc_d1;
    logic              acc_d2;
    logic [PC_W-1:0]   prev_pc;
    logic [TAG_W-1:0]  prev_tag;
    logic [TAG_W-1:0]  prev2_tag;
    src_t              s1;
    src_t              s2;
    logic [DATA_W-1:0] exp_value;
    logic              dep_ok;
    logic              woke_recent;
    logic              full_exp;

    function automatic logic [DATA_W-1:0] alu_ref(input alu_op_t op,
                                                  input logic [DATA_W-1:0] x,
                                                  input logic [DATA_W-1:0] y);
        logic lt;
        lt = (x[DATA_W-1] != y[DATA_W-1]) ? x[DATA_W-1] : (x < y);  // signed less-than.
        case (op)
            ADD:     return x + y;
            SUB:     return x - y;
            AND:     return x & y;
            OR:      return x | y;
            XOR:     return x ^ y;
            SLT:     return DATA_W'(lt);
            default: return '0;
        endcase
    endfunction

    assign in_s     = dispatch_entry;
    assign res_s    = result;
    assign accept   = dispatch_en & ~full;
    assign full_exp = (occ - (result_valid ? 1 : 0)) == RS_SIZE;

    // ==============================
    // shadow state
    // ==============================

    always_ff @(posedge clock) begin
        if (rst) begin
            occ           <= 0;
            seen_dispatch <= 1'b0;
            pending       <= '0;
            produced      <= '0;
            prev_valid    <= 1'b0;
            prev2_valid   <= 1'b0;
            acc_d1        <= 1'b0;
            acc_d2        <= 1'b0;
        end else begin
            occ <= occ + (accept ? 1 : 0) - (result_valid ? 1 : 0);
            if (accept) begin
                seen_dispatch            <= 1'b1;
                pending[in_s.dest_tag]   <= 1'b1;
                produced[in_s.dest_tag]  <= 1'b0;
                op_q[in_s.dest_tag]      <= in_s.op;
                s1_q[in_s.dest_tag]      <= in_s.src1;
                s2_q[in_s.dest_tag]      <= in_s.src2;
            end
            if (result_valid) begin
                pending[res_s.dest_tag]  <= 1'b0;
                produced[res_s.dest_tag] <= 1'b1;
                prod_val[res_s.dest_tag] <= res_s.value;
            end
            prev_valid  <= result_valid;
            prev_pc     <= res_s.pc;
            prev_tag    <= res_s.dest_tag;
            prev2_valid <= prev_valid;
            prev2_tag   <= prev_tag;
            acc_d1      <= accept;
            acc_d2      <= acc_d1;
        end
    end

    // expected value of the result on the bus, from the operands seen at dispatch.
    always_comb begin
        s1          = s1_q[res_s.dest_tag];
        s2          = s2_q[res_s.dest_tag];
        exp_value   = alu_ref(op_q[res_s.dest_tag],
                              s1.ready ? s1.value : prod_val[s1.tag],
                              s2.ready ? s2.value : prod_val[s2.tag]);
        dep_ok      = (s1.ready || produced[s1.tag]) && (s2.ready || produced[s2.tag]);
        woke_recent = prev2_valid && ((!s1.ready && s1.tag == prev2_tag) ||
                                      (!s2.ready && s2.tag == prev2_tag));
    end

    // ==============================
    // assertions
    // ==============================

    a_reset_quiet: assert property (@(posedge clock) disable iff (rst)
        !seen_dispatch |-> !result_valid && !full)
        else begin
            error_count++;
            $error("result_valid or full went high before the first dispatch");
        end

    a_value: assert property (@(posedge clock) disable iff (rst)
        result_valid |-> res_s.value == exp_value)
        else begin
            error_count++;
            $error("Mismatch result.value: got %h expected %h", res_s.value, exp_value);
        end

    a_tag_known: assert property (@(posedge clock) disable iff (rst)
        result_valid |-> pending[res_s.dest_tag])
        else begin
            error_count++;
            $error("result for tag %0d does not match any accepted dispatch", res_s.dest_tag);
        end

    a_wakeup: assert property (@(posedge clock) disable iff (rst)
        result_valid |-> dep_ok)
        else begin
            error_count++;
            $error("tag %0d issued before its source operand was produced", res_s.dest_tag);
        end

    a_full: assert property (@(posedge clock) disable iff (rst)
        full == full_exp)
        else begin
            error_count++;
            $error("Mismatch full: got %h expected %h", full, full_exp);
        end

    // back-to-back issues from an unchanged ready set leave in pc order.
    a_oldest: assert property (@(posedge clock) disable iff (rst)
        result_valid && prev_valid && !acc_d2 && !woke_recent |-> res_s.pc > prev_pc)
        else begin
            error_count++;
            $error("Mismatch result.pc: got %h expected above %h", res_s.pc, prev_pc);
        end
endmodule

bind rs_top rs_checker #(.PC_W(PC_W)) u_checker (
    .clock(clock),
    .rst(rst),
    .dispatch_en(dispatch_en),
    .dispatch_entry(dispatch_entry),
    .full(full),
    .result_valid(result_valid),
    .result(result)
);

// File: tb/rs_tb.sv
module rs_tb import rs_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PC_W     = 32;
    localparam int N_RANDOM = 40;
    localparam int N_PAIRS  = 12;
    localparam int N_ROUNDS = 2;
    localparam int TIMEOUT  = 8 + (N_RANDOM + 5) + N_PAIRS * 8 + N_ROUNDS * 40 + 200;

    typedef struct packed {
        logic [PC_W-1:0]  pc;
        alu_op_t          op;
        logic [TAG_W-1:0] dest_tag;
        src_t             src1;
        src_t             src2;
    } rs_entry_t;

    logic                          clock;
    logic                          rst;
    logic                          dispatch_en;
    logic [PC_W+ENTRY_BASE_W-1:0]  dispatch_entry;
    logic                          full;
    logic                          result_valid;
    logic [PC_W+RESULT_BASE_W-1:0] result;

    logic [31:0] rng_state = 32'd1131;
    logic [7:0]  pc_seq = '0;  // low pc byte, keeps every pc unique.
    int          cycles = 0;
    int          dispatched = 0;
    int          results_seen = 0;
    alu_op_t     op;

    rs_clock_gen u_clk (.clock(clock), .rst(rst));

    rs_top #(.PC_W(PC_W)) u_dut (
        .clock(clock), .rst(rst),
        .dispatch_en(dispatch_en), .dispatch_entry(dispatch_entry), .full(full),
        .result_valid(result_valid), .result(result)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic alu_op_t random_op();
        logic [31:0] r;
        r = next_rand() % 32'd6;
        return alu_op_t'(r[2:0]);
    endfunction

    function automatic src_t make_src(input logic rdy, input logic [TAG_W-1:0] tag);
        src_t s;
        s.ready = rdy;
        s.tag   = tag;
        s.value = next_rand();  // ignored by the DUT while not ready.
        return s;
    endfunction

    task automatic send(input alu_op_t o, input logic [TAG_W-1:0] dest,
                        input src_t s1, input src_t s2);
        rs_entry_t   e;
        logic [31:0] r;
        r          = next_rand();
        e.pc       = {r[31:8], pc_seq};
        e.op       = o;
        e.dest_tag = dest;
        e.src1     = s1;
        e.src2     = s2;
        pc_seq++;
        @(negedge clock);
        while (full) begin
            dispatch_en = 1'b0;
            @(negedge clock);
        end
        dispatch_en    = 1'b1;
        dispatch_entry = e;
        dispatched++;
    endtask

    task automatic idle_cycle();
        @(negedge clock);
        dispatch_en = 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (results_seen != dispatched) @(negedge clock);
    endtask

    // tag 63 is never used by a real dispatch.
    task automatic strobe_while_full();
        rs_entry_t e;
        e          = '0;
        e.pc       = {24'hFFFFFF, pc_seq};
        e.dest_tag = '1;
        e.src1     = make_src(1'b1, '0);
        e.src2     = make_src(1'b1, '0);
        pc_seq++;
        @(negedge clock);
        while (!full) @(negedge clock);
        dispatch_en    = 1'b1;
        dispatch_entry = e;
        idle_cycle();
    endtask

    always @(posedge clock) begin
        cycles++;
        if (result_valid) results_seen++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run stopped after %0d cycles waiting for results", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        dispatch_en    = 1'b0;
        dispatch_entry = '0;
        @(negedge rst);
        repeat (3) idle_cycle();

        // ==============================
        // ready operands, every op
        // ==============================
        for (int i = 0; i < N_RANDOM; i++) begin
            if (i < 6) op = alu_op_t'(3'(i));
            else op = random_op();
            send(op, TAG_W'(i), make_src(1'b1, '0), make_src(1'b1, '0));
        end
        drain();

        // ==============================
        // wakeup pairs
        // ==============================
        for (int i = 0; i < N_PAIRS; i++) begin
            send(random_op(), TAG_W'(2 * i), make_src(1'b1, '0), make_src(1'b1, '0));
            if (i % 2 == 1) idle_cycle();  // consumer lands on the broadcast cycle.
            send(random_op(), TAG_W'(2 * i + 1), make_src(1'b0, TAG_W'(2 * i)),
                 make_src(i % 3 != 0, TAG_W'(2 * i)));
            drain();
        end

        // ==============================
        // full table, oldest first
        // ==============================
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int k = 0; k < RS_SIZE - 1; k++) begin
                send(random_op(), TAG_W'(k), make_src(1'b0, TAG_W'(15)),
                     make_src(1'b1, '0));
            end
            send(random_op(), TAG_W'(15), make_src(1'b1, '0), make_src(1'b1, '0));
            strobe_while_full();
            drain();
        end

        repeat (4) idle_cycle();
        $display("errors: %0d, dispatched: %0d, results: %0d",
                 u_dut.u_checker.error_count, dispatched, results_seen);
        if (u_dut.u_checker.error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end
endmodule

// File: build.f
src/rs_pkg.sv
src/ps_tree.sv
src/pc_sel.sv
src/rs_dispatch.sv
src/rs_table.sv
src/rs_issue.sv
src/rs_top.sv
tb/rs_clock_gen.sv
tb/rs_checker.sv
tb/rs_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rs_tb -f build.f -o rs_sim
./obj_dir/rs_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
